//--- tlb_params.svh
// TLB sizing macros, field widths, register map and command codes
`ifndef TLB_PARAMS_SVH
`define TLB_PARAMS_SVH

`define TLB_NUM      32
`define TLB_IDX_W    5
`define TLB_VPN2_W   19
`define TLB_ASID_W   10
`define TLB_PFN_W    20

// wishbone word addresses
`define TLB_REG_INDEX 3'd0
`define TLB_REG_HI    3'd1
`define TLB_REG_LO0   3'd2
`define TLB_REG_LO1   3'd3
`define TLB_REG_CMD   3'd4

`define TLB_CMD_WI   32'd1
`define TLB_CMD_R    32'd2
`define TLB_CMD_P    32'd3

`endif

//--- tlb_pkg.sv
// TLB types: page and entry records, register word views, lookup and bus bundles
`default_nettype none
`include "tlb_params.svh"

package tlb_pkg;

    typedef struct packed {
        logic [`TLB_PFN_W-1:0] pfn;
        logic [2:0]            c;
        logic                  d;
        logic                  v;
    } tlb_page_t;

    typedef struct packed {
        logic [`TLB_VPN2_W-1:0] vpn2;
        logic [`TLB_ASID_W-1:0] asid;
        logic                   g;
        tlb_page_t              page0;
        tlb_page_t              page1;
    } tlb_entry_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // cp0 register word, EntryHi or EntryLo layout
    typedef struct packed {
        logic [`TLB_VPN2_W-1:0] vpn2;
        logic [2:0]             pad;
        logic [`TLB_ASID_W-1:0] asid;
    } tlb_hi_t;

    typedef struct packed {
        logic [5:0]            pad;
        logic [`TLB_PFN_W-1:0] pfn;
        logic [2:0]            c;
        logic                  d;
        logic                  v;
        logic                  g;
    } tlb_lo_t;

    typedef union packed {
        tlb_hi_t hi;
        tlb_lo_t lo;
    } tlb_reg_word_u;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic        valid;
        logic [31:0] vaddr;
    } lookup_req_t;

    typedef struct packed {
        logic        valid;
        logic        hit;
        logic [31:0] paddr;
        logic [2:0]  c;
        logic        d;
        logic        v;
    } lookup_rsp_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [2:0]  adr;
        logic [31:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat_r;
    } wb_rsp_t;

endpackage

`default_nettype wire

//--- tlb_found_compare.sv
// associative match of all TLB entries against two lookup keys and a probe key
`timescale 1ns/1ns
`default_nettype none
`include "tlb_params.svh"

module tlb_found_compare #(
    parameter int tlb_num = `TLB_NUM
) (
    input  logic                           clk,
    input  logic [tlb_num-1:0]             all_e,
    input  logic [tlb_num-1:0]             all_g,
    input  logic [tlb_num*`TLB_ASID_W-1:0] all_asid,
    input  logic [tlb_num*`TLB_VPN2_W-1:0] all_vpn2,
    input  logic [`TLB_ASID_W-1:0]         s0_asid,
    input  logic [`TLB_ASID_W-1:0]         s1_asid,
    input  logic [`TLB_VPN2_W-1:0]         s0_vpn2,
    input  logic [`TLB_VPN2_W-1:0]         s1_vpn2,
    input  logic [`TLB_VPN2_W-1:0]         s_vpn2,
    input  logic [`TLB_ASID_W-1:0]         s_asid,
    output logic [tlb_num-1:0]             found0,
    output logic [tlb_num-1:0]             found1,
    output logic                           s_e,
    output logic [$clog2(tlb_num)-1:0]     s_index
);
    localparam int idx_w = $clog2(tlb_num);

    logic [tlb_num-1:0] found_search;

    // global entries skip the asid compare
    function automatic logic match_at(
        input int                     i,
        input logic [`TLB_VPN2_W-1:0] vpn2,
        input logic [`TLB_ASID_W-1:0] asid
    );
        return all_e[i]
            && (all_g[i] || (all_asid[i*`TLB_ASID_W +: `TLB_ASID_W] == asid))
            && (all_vpn2[i*`TLB_VPN2_W +: `TLB_VPN2_W] == vpn2);
    endfunction

    always_comb begin
        for (int i = 0; i < tlb_num; i++) begin
            found0[i]       = match_at(i, s0_vpn2, s0_asid);
            found1[i]       = match_at(i, s1_vpn2, s1_asid);
            found_search[i] = match_at(i, s_vpn2, s_asid);
        end
    end

    assign s_e = |found_search;

    // or-encode, valid for a one-hot probe vector
    always_comb begin
        s_index = '0;
        for (int i = 0; i < tlb_num; i++) begin
            if (found_search[i]) begin
                s_index = s_index | idx_w'(i);
            end
        end
    end

    a_probe_onehot: assert property (@(posedge clk) $onehot0(found_search))
        else $error("probe matched more than one TLB entry");

endmodule

`default_nettype wire

//--- tlb_entry_array.sv
// TLB entry storage with indexed write and read ports and flattened match fields
`timescale 1ns/1ns
`default_nettype none
`include "tlb_params.svh"

module tlb_entry_array import tlb_pkg::*; #(
    parameter int tlb_num = `TLB_NUM
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           we,
    input  logic [$clog2(tlb_num)-1:0]     w_index,
    input  tlb_entry_t                     w_entry,
    input  logic [$clog2(tlb_num)-1:0]     r_index,
    output tlb_entry_t                     r_entry,
    output logic [tlb_num-1:0]             all_e,
    output logic [tlb_num-1:0]             all_g,
    output logic [tlb_num*`TLB_ASID_W-1:0] all_asid,
    output logic [tlb_num*`TLB_VPN2_W-1:0] all_vpn2,
    output tlb_page_t [2*tlb_num-1:0]      all_pages
);
    tlb_entry_t         mem [tlb_num];
    logic [tlb_num-1:0] e_q;

    always_ff @(posedge clk) begin
        if (we) begin
            mem[w_index] <= w_entry;
        end
    end

    // entry becomes live on its first write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            e_q <= '0;
        end else if (we) begin
            e_q[w_index] <= 1'b1;
        end
    end

    assign r_entry = mem[r_index];
    assign all_e   = e_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // flatten for the comparator and lookup
    for (genvar i = 0; i < tlb_num; i++) begin : g_flat
        assign all_g[i]                                     = mem[i].g;
        assign all_asid[i*`TLB_ASID_W +: `TLB_ASID_W]       = mem[i].asid;
        assign all_vpn2[i*`TLB_VPN2_W +: `TLB_VPN2_W]       = mem[i].vpn2;
        // even page at 2i and odd page at 2i+1
        assign all_pages[2*i]                               = mem[i].page0;
        assign all_pages[2*i+1]                             = mem[i].page1;
    end

    a_write_known: assert property (
        @(posedge clk) disable iff (!rst_n) we |-> !$isunknown({w_index, w_entry})
    ) else $error("TLB write with an unknown index or entry");

endmodule

`default_nettype wire

//--- tlb_wb_regs.sv
// Wishbone slave with Index, EntryHi, EntryLo0/1 staging registers and tlbwi, tlbr, tlbp
`timescale 1ns/1ns
`default_nettype none
`include "tlb_params.svh"

module tlb_wb_regs import tlb_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  wb_req_t                wb_req,
    output wb_rsp_t                wb_rsp,
    output logic                   we,
    output logic [`TLB_IDX_W-1:0]  w_index,
    output tlb_entry_t             w_entry,
    output logic [`TLB_IDX_W-1:0]  r_index,
    input  tlb_entry_t             r_entry,
    output logic [`TLB_VPN2_W-1:0] probe_vpn2,
    output logic [`TLB_ASID_W-1:0] probe_asid,
    output logic [`TLB_ASID_W-1:0] cur_asid,
    input  logic                   probe_hit,
    input  logic [`TLB_IDX_W-1:0]  probe_index
);
    logic                  ack_q;
    logic                  p_q;
    logic [`TLB_IDX_W-1:0] idx_q;
    tlb_reg_word_u         hi_q;
    tlb_reg_word_u         lo0_q;
    tlb_reg_word_u         lo1_q;
    tlb_reg_word_u         hi_wr;
    tlb_reg_word_u         lo_wr;
    logic [31:0]           rd_data;
    logic                  access;
    logic                  wr_fire;
    logic                  cmd_wi;
    logic                  cmd_r;
    logic                  cmd_p;

    function automatic tlb_page_t lo_to_page(input tlb_reg_word_u w);
        return '{pfn: w.lo.pfn, c: w.lo.c, d: w.lo.d, v: w.lo.v};
    endfunction

    function automatic tlb_reg_word_u page_to_lo(input tlb_page_t p, input logic g);
        tlb_reg_word_u w;
        w      = '0;
        w.lo.pfn = p.pfn;
        w.lo.c   = p.c;
        w.lo.d   = p.d;
        w.lo.v   = p.v;
        w.lo.g   = g;
        return w;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus decode, one wait state
    assign access  = wb_req.cyc & wb_req.stb;
    assign wr_fire = access & wb_req.we & ack_q;
    assign cmd_wi  = wr_fire && (wb_req.adr == `TLB_REG_CMD) && (wb_req.dat_w == `TLB_CMD_WI);
    assign cmd_r   = wr_fire && (wb_req.adr == `TLB_REG_CMD) && (wb_req.dat_w == `TLB_CMD_R);
    assign cmd_p   = wr_fire && (wb_req.adr == `TLB_REG_CMD) && (wb_req.dat_w == `TLB_CMD_P);

    // pads read back as zero
    always_comb begin
        hi_wr        = wb_req.dat_w;
        hi_wr.hi.pad = '0;
        lo_wr        = wb_req.dat_w;
        lo_wr.lo.pad = '0;
    end

    always_comb begin
        case (wb_req.adr)
            `TLB_REG_INDEX: rd_data = {p_q, {(31-`TLB_IDX_W){1'b0}}, idx_q};
            `TLB_REG_HI:    rd_data = hi_q;
            `TLB_REG_LO0:   rd_data = lo0_q;
            `TLB_REG_LO1:   rd_data = lo1_q;
            default:        rd_data = '0;
        endcase
    end

    assign wb_rsp.ack   = ack_q;
    assign wb_rsp.dat_r = rd_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
            p_q   <= 1'b0;
            idx_q <= '0;
            hi_q  <= '0;
            lo0_q <= '0;
            lo1_q <= '0;
        end else begin
            ack_q <= access & ~ack_q;
            if (wr_fire) begin
                case (wb_req.adr)
                    `TLB_REG_INDEX: begin
                        p_q   <= wb_req.dat_w[31];
                        idx_q <= wb_req.dat_w[`TLB_IDX_W-1:0];
                    end
                    `TLB_REG_HI:  hi_q  <= hi_wr;
                    `TLB_REG_LO0: lo0_q <= lo_wr;
                    `TLB_REG_LO1: lo1_q <= lo_wr;
                    default: ;
                endcase
            end
            // tlbr, g goes back into both halves
            if (cmd_r) begin
                hi_q         <= '0;
                hi_q.hi.vpn2 <= r_entry.vpn2;
                hi_q.hi.asid <= r_entry.asid;
                lo0_q        <= page_to_lo(r_entry.page0, r_entry.g);
                lo1_q        <= page_to_lo(r_entry.page1, r_entry.g);
            end
            // tlbp, index kept on a miss
            if (cmd_p) begin
                p_q <= ~probe_hit;
                if (probe_hit) begin
                    idx_q <= probe_index;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign we      = cmd_wi;
    assign w_index = idx_q;
    assign r_index = idx_q;

    always_comb begin
        w_entry.vpn2  = hi_q.hi.vpn2;
        w_entry.asid  = hi_q.hi.asid;
        w_entry.g     = lo0_q.lo.g & lo1_q.lo.g;
        w_entry.page0 = lo_to_page(lo0_q);
        w_entry.page1 = lo_to_page(lo1_q);
    end

    assign probe_vpn2 = hi_q.hi.vpn2;
    assign probe_asid = hi_q.hi.asid;
    assign cur_asid   = hi_q.hi.asid;

    a_ack_in_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) ack_q |-> (wb_req.cyc && wb_req.stb)
    ) else $error("ack high without an active bus cycle");

endmodule

`default_nettype wire

//--- tlb_lookup.sv
// two translation ports, hit page select and registered responses
`timescale 1ns/1ns
`default_nettype none
`include "tlb_params.svh"

module tlb_lookup import tlb_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n,
    input  lookup_req_t                  req0,
    input  lookup_req_t                  req1,
    input  logic [`TLB_ASID_W-1:0]       cur_asid,
    input  logic [`TLB_NUM-1:0]          found0,
    input  logic [`TLB_NUM-1:0]          found1,
    input  tlb_page_t [2*`TLB_NUM-1:0]   all_pages,
    output logic [`TLB_VPN2_W-1:0]       key0_vpn2,
    output logic [`TLB_VPN2_W-1:0]       key1_vpn2,
    output lookup_rsp_t                  rsp0,
    output lookup_rsp_t                  rsp1
);
    lookup_rsp_t rsp0_d;
    lookup_rsp_t rsp1_d;

    // one-hot found vector, so an or-select is enough
    function automatic lookup_rsp_t translate(
        input lookup_req_t               req,
        input logic [`TLB_NUM-1:0]       found,
        input tlb_page_t [2*`TLB_NUM-1:0] pages
    );
        tlb_page_t   pg;
        lookup_rsp_t rsp;
        pg = '0;
        for (int i = 0; i < `TLB_NUM; i++) begin
            if (found[i]) begin
                pg = pg | pages[2*i + int'(req.vaddr[12])];
            end
        end
        rsp.valid = req.valid;
        rsp.hit   = |found;
        rsp.paddr = rsp.hit ? {pg.pfn, req.vaddr[11:0]} : 32'h0;
        rsp.c     = pg.c;
        rsp.d     = pg.d;
        rsp.v     = pg.v;
        return rsp;
    endfunction

    assign key0_vpn2 = req0.vaddr[31:13];
    assign key1_vpn2 = req1.vaddr[31:13];

    assign rsp0_d = translate(req0, found0, all_pages);
    assign rsp1_d = translate(req1, found1, all_pages);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp0.valid <= 1'b0;
            rsp1.valid <= 1'b0;
        end else begin
            rsp0 <= rsp0_d;
            rsp1 <= rsp1_d;
        end
    end

    // EntryHi asid must not move on the edge that captures a lookup
    a_asid_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (req0.valid || req1.valid) |=> $stable(cur_asid)
    ) else $error("asid changed on a lookup capture edge");

endmodule

`default_nettype wire

//--- tlb_top.sv
// TLB top: register block, entry array, comparator and lookup stage
`timescale 1ns/1ns
`default_nettype none
`include "tlb_params.svh"

module tlb_top import tlb_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  wb_req_t     wb_req,
    input  lookup_req_t req0,
    input  lookup_req_t req1,
    output wb_rsp_t     wb_rsp,
    output lookup_rsp_t rsp0,
    output lookup_rsp_t rsp1
);
    logic                            we;
    logic [`TLB_IDX_W-1:0]           w_index;
    tlb_entry_t                      w_entry;
    logic [`TLB_IDX_W-1:0]           r_index;
    tlb_entry_t                      r_entry;
    logic [`TLB_VPN2_W-1:0]          probe_vpn2;
    logic [`TLB_ASID_W-1:0]          probe_asid;
    logic [`TLB_ASID_W-1:0]          cur_asid;
    logic                            probe_hit;
    logic [`TLB_IDX_W-1:0]           probe_index;
    logic [`TLB_NUM-1:0]             all_e;
    logic [`TLB_NUM-1:0]             all_g;
    logic [`TLB_NUM*`TLB_ASID_W-1:0] all_asid;
    logic [`TLB_NUM*`TLB_VPN2_W-1:0] all_vpn2;
    tlb_page_t [2*`TLB_NUM-1:0]      all_pages;
    logic [`TLB_NUM-1:0]             found0;
    logic [`TLB_NUM-1:0]             found1;
    logic [`TLB_VPN2_W-1:0]          key0_vpn2;
    logic [`TLB_VPN2_W-1:0]          key1_vpn2;

    tlb_wb_regs u_regs (
        .clk, .rst_n, .wb_req, .wb_rsp, .we, .w_index, .w_entry, .r_index, .r_entry,
        .probe_vpn2, .probe_asid, .cur_asid, .probe_hit, .probe_index
    );

    tlb_entry_array #(.tlb_num(`TLB_NUM)) u_array (
        .clk, .rst_n, .we, .w_index, .w_entry, .r_index, .r_entry,
        .all_e, .all_g, .all_asid, .all_vpn2, .all_pages
    );

    // both lookup ports share the current asid
    tlb_found_compare #(.tlb_num(`TLB_NUM)) u_compare (
        .clk, .all_e, .all_g, .all_asid, .all_vpn2,
        .s0_asid(cur_asid), .s1_asid(cur_asid),
        .s0_vpn2(key0_vpn2), .s1_vpn2(key1_vpn2),
        .s_vpn2(probe_vpn2), .s_asid(probe_asid),
        .found0, .found1, .s_e(probe_hit), .s_index(probe_index)
    );

    tlb_lookup u_lookup (
        .clk, .rst_n, .req0, .req1, .cur_asid, .found0, .found1, .all_pages,
        .key0_vpn2, .key1_vpn2, .rsp0, .rsp1
    );

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
// testbench clock, 4 ns period, and reset held low for 3 cycles
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // release just after the third rising edge
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- tlb_tb.sv
// TLB testbench that runs the script in tlb_input.txt over the Wishbone port and the
// lookup ports, and checks read data and translation results
`timescale 1ns/1ns
`default_nettype none

module tlb_tb import tlb_pkg::*; ();

    localparam int          ack_timeout   = 16;
    localparam int          reset_timeout = 20;
    localparam logic [31:0] lfsr_seed     = 32'hb287_f2a1;

    logic        clk;
    logic        rst_n;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    lookup_req_t req0;
    lookup_req_t req1;
    lookup_rsp_t rsp0;
    lookup_rsp_t rsp1;

    int          errors;
    int          checks;
    int          timeouts;
    int          fd;
    logic [31:0] lfsr;

    // staging registers and entries as the script leaves them
    logic [31:0] model_hi;
    logic [31:0] model_lo0;
    logic [31:0] model_lo1;
    logic [4:0]  model_idx;
    logic [31:0] model_ent_hi  [32];
    logic [31:0] model_ent_lo0 [32];
    logic [31:0] model_ent_lo1 [32];
    logic [31:0] model_ent_e;

    tb_clk_gen u_clk (.clk, .rst_n);

    tlb_top u_dut (
        .clk, .rst_n, .wb_req, .req0, .req1, .wb_rsp, .rsp0, .rsp1
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error %s: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    task automatic idle_random();
        logic [1:0] n;
        lfsr = lfsr_step(lfsr);
        n[0] = lfsr[0];
        lfsr = lfsr_step(lfsr);
        n[1] = lfsr[0];
        for (int i = 0; i < n; i++) begin
            next_cycle();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // global entries match any asid
    function automatic int find_entry(input logic [18:0] vpn2, input logic [9:0] asid);
        int at;
        at = -1;
        for (int i = 0; i < 32; i++) begin
            if (model_ent_e[i] && model_ent_hi[i][31:13] == vpn2
                    && ((model_ent_lo0[i][0] && model_ent_lo1[i][0])
                        || model_ent_hi[i][9:0] == asid)) begin
                at = i;
            end
        end
        return at;
    endfunction

    // register and command effects of one bus write
    task automatic track_write(input logic [2:0] adr, input logic [31:0] dat);
        int   at;
        logic g;
        case (adr)
            3'd0: model_idx = dat[4:0];
            3'd1: model_hi = dat;
            3'd2: model_lo0 = dat;
            3'd3: model_lo1 = dat;
            3'd4: begin
                if (dat == 32'd1) begin
                    model_ent_hi[model_idx]  = model_hi;
                    model_ent_lo0[model_idx] = model_lo0;
                    model_ent_lo1[model_idx] = model_lo1;
                    model_ent_e[model_idx]   = 1'b1;
                end else if (dat == 32'd2) begin
                    g         = model_ent_lo0[model_idx][0] & model_ent_lo1[model_idx][0];
                    model_hi  = model_ent_hi[model_idx];
                    model_lo0 = {model_ent_lo0[model_idx][31:1], g};
                    model_lo1 = {model_ent_lo1[model_idx][31:1], g};
                end else if (dat == 32'd3) begin
                    at = find_entry(model_hi[31:13], model_hi[9:0]);
                    if (at >= 0) begin
                        model_idx = at[4:0];
                    end
                end
            end
            default: ;
        endcase
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one classic cycle held until ack is seen on an edge
    task automatic bus_access(input string name, input logic wr, input logic [2:0] adr,
                              input logic [31:0] dat, output logic [31:0] rdata);
        int   waited;
        logic got_ack;
        waited       = 0;
        got_ack      = 1'b0;
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = wr;
        wb_req.adr   = adr;
        wb_req.dat_w = dat;
        while (!got_ack && waited < ack_timeout) begin
            next_cycle();
            waited++;
            got_ack = (wb_rsp.ack === 1'b1);
        end
        rdata = wb_rsp.dat_r;
        if (got_ack) begin
            check_value($sformatf("%s ack latency", name), 32'd1, waited);
            // the ack edge is where a write lands
            next_cycle();
        end else begin
            timeouts++;
            $display("timeout: no Wishbone ack for %s", name);
        end
        wb_req = '0;
    endtask

    // response due exactly one cycle after the request
    task automatic run_lookup(input string name, input int port, input logic [31:0] vaddr,
                              input logic exp_hit, input logic [31:0] exp_paddr);
        lookup_rsp_t rsp;
        lookup_rsp_t other;
        int          at;
        logic [31:0] lo;
        if (port == 0) begin
            req0.valid = 1'b1;
            req0.vaddr = vaddr;
        end else begin
            req1.valid = 1'b1;
            req1.vaddr = vaddr;
        end
        next_cycle();
        rsp   = (port == 0) ? rsp0 : rsp1;
        other = (port == 0) ? rsp1 : rsp0;
        check_value($sformatf("%s valid", name), 32'd1, {31'b0, rsp.valid});
        check_value($sformatf("%s idle port valid", name), 32'd0, {31'b0, other.valid});
        check_value($sformatf("%s hit", name), {31'b0, exp_hit}, {31'b0, rsp.hit});
        check_value($sformatf("%s paddr", name), exp_paddr, rsp.paddr);
        if (exp_hit) begin
            at = find_entry(vaddr[31:13], model_hi[9:0]);
            if (at < 0) begin
                errors++;
                $display("%s expects a hit on a page that was never written", name);
            end else begin
                lo = vaddr[12] ? model_ent_lo1[at] : model_ent_lo0[at];
                check_value($sformatf("%s c d v", name), {27'b0, lo[5:1]},
                            {27'b0, rsp.c, rsp.d, rsp.v});
            end
        end
        req0.valid = 1'b0;
        req1.valid = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        logic [7:0]  kind;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        int          code;
        int          ch;
        int          op;
        int          rst_wait;
        logic        in_run;
        logic        done;
        string       name;

        wb_req      = '0;
        req0        = '0;
        req1        = '0;
        errors      = 0;
        checks      = 0;
        timeouts    = 0;
        lfsr        = lfsr_seed;
        model_hi    = '0;
        model_lo0   = '0;
        model_lo1   = '0;
        model_idx   = '0;
        model_ent_e = '0;
        rst_wait    = 0;
        while (rst_n !== 1'b1 && rst_wait < reset_timeout) begin
            @(posedge clk);
            rst_wait++;
        end
        if (rst_n !== 1'b1) begin
            timeouts++;
            $display("timeout: reset was never released");
        end
        #1;

        fd = $fopen("tlb_input.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open tlb_input.txt");
        end
        done   = (fd == 0) || (timeouts != 0);
        op     = 0;
        in_run = 1'b0;
        while (!done) begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1) begin
                done = 1'b1;
            end else if (kind == "#") begin
                ch = $fgetc(fd);
                while (ch != "\n" && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else begin
                op++;
                // adjacent lookups go out back to back
                if (!(kind == "l" && in_run)) begin
                    idle_random();
                end
                in_run = (kind == "l");
                case (kind)
                    "w": begin
                        code = $fscanf(fd, "%h %h", f1, f2);
                        name = $sformatf("op %0d write adr %0d", op, f1);
                        if (code == 2) begin
                            bus_access(name, 1'b1, f1[2:0], f2, f3);
                            track_write(f1[2:0], f2);
                        end
                    end
                    "r": begin
                        code = $fscanf(fd, "%h %h", f1, f2);
                        name = $sformatf("op %0d read adr %0d", op, f1);
                        if (code == 2) begin
                            bus_access(name, 1'b0, f1[2:0], 32'h0, f3);
                            check_value(name, f2, f3);
                        end
                    end
                    "l": begin
                        code = $fscanf(fd, "%h %h %h %h", f1, f2, f3, f4);
                        name = $sformatf("op %0d lookup port %0d", op, f1);
                        if (code == 4) begin
                            run_lookup(name, f1, f2, f3[0], f4);
                        end else begin
                            code = 0;
                        end
                    end
                    default: begin
                        code = 0;
                    end
                endcase
                if (code == 0 || code == 1 || code == -1) begin
                    errors++;
                    $display("op %0d in tlb_input.txt is malformed", op);
                    done = 1'b1;
                end
                if (timeouts != 0) begin
                    done = 1'b1;
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0 && checks > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tlb_input.txt
# w adr data | r adr expected | l port vaddr hit paddr, all in hex
# adjacent l lines are issued on consecutive cycles
# after reset nothing maps
l 0 00000000 0 00000000
l 1 00402000 0 00000000
# staging registers, pads read back as zero
w 1 ffffffff
r 1 ffffe3ff
w 2 ffffffff
r 2 03ffffff
w 0 ffffffe5
r 0 80000005
# entry 5: asid 011, not global
w 0 00000005
w 1 00400011
w 2 0048d15e
w 3 002af352
w 4 00000001
# entry 9: global
w 0 00000009
w 1 100003ff
w 2 0001ddef
w 3 00022201
w 4 00000001
# entry 12: only lo0 has g set, so the entry is not global
w 0 0000000c
w 1 20000022
w 2 0000401b
w 3 0000405a
w 4 00000001
# tlbr on 5, then 12 and 9, g shows in both lo registers
w 0 00000005
w 4 00000002
r 1 00400011
r 2 0048d15e
r 3 002af352
w 0 0000000c
w 4 00000002
r 1 20000022
r 2 0000401a
r 3 0000405a
w 0 00000009
w 4 00000002
r 2 0001ddef
r 3 00022201
# tlbp: global hit, asid miss sets P and keeps the index, then a plain hit
w 1 10000055
w 4 00000003
r 0 00000009
w 1 00400012
w 4 00000003
r 0 80000009
w 1 00400011
w 4 00000003
r 0 00000005
# lookups with asid 011
l 0 00400abc 1 12345abc
l 1 00401def 1 0abcddef
l 0 10000123 1 00777123
l 1 10001fff 1 00888fff
l 0 20000004 0 00000000
l 1 30000000 0 00000000
# lookups with asid 022
w 1 00000022
l 0 20000004 1 00100004
l 1 00400abc 0 00000000
l 0 10000123 1 00777123

//--- list.f
+incdir+.
tlb_pkg.sv
tlb_found_compare.sv
tlb_entry_array.sv
tlb_wb_regs.sv
tlb_lookup.sv
tlb_top.sv
tb_clk_gen.sv
tlb_tb.sv

//--- Bender.yml
package:
  name: tlb

export_include_dirs:
  - .

sources:
  - tlb_pkg.sv
  - tlb_found_compare.sv
  - tlb_entry_array.sv
  - tlb_wb_regs.sv
  - tlb_lookup.sv
  - tlb_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tlb_tb.sv
